/* common/soc_consts.svh */
`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

// data ram, 32-bit words
`define RAM_BASE           64'h0000_0000_0000_1000
`define RAM_WORDS          1024
`define RAM_INDEX_W        10

// read-only key code register
`define KEY_ADDR           64'h0000_0000_0000_0F00

// plic, priority of id n at base + 4*n
`define PLIC_BASE          64'h0000_0000_0C00_0000
`define PLIC_PENDING       (`PLIC_BASE + 64'h1000)

// enable word per context
`define PLIC_ENABLE        (`PLIC_BASE + 64'h2000)
`define PLIC_CTX_EN_STRIDE 64'h80

// threshold and claim per context
`define PLIC_THRESHOLD     (`PLIC_BASE + 64'h20_0000)
`define PLIC_CLAIM         (`PLIC_THRESHOLD + 64'h4)
`define PLIC_CTX_STRIDE    64'h1000

// id 0 is reserved for no interrupt
`define PLIC_SOURCES       6

`endif

/* common/soc_pkg.sv */
package soc_pkg;

    // 64-bit address and data as the core sees the bus
    typedef logic [63:0] bus_word_t;

    // one word of the data ram
    typedef logic [31:0] ram_word_t;

    // load/store type from the core
    // stores reuse 000 to 011 as sb, sh, sw and sd
    typedef enum logic [2:0] {
        ls_lb  = 3'b000,
        ls_lh  = 3'b001,
        ls_lw  = 3'b010,
        ls_ld  = 3'b011,
        ls_lbu = 3'b100,
        ls_lhu = 3'b101,
        ls_lwu = 3'b110
    } ls_type_e;

    // decoded bus target
    typedef enum logic [3:0] {
        rgn_ram,
        rgn_key,
        rgn_plic_prio,
        rgn_plic_pend,
        rgn_plic_en0,
        rgn_plic_en1,
        rgn_plic_thr0,
        rgn_plic_thr1,
        rgn_plic_claim0,
        rgn_plic_claim1,
        rgn_none
    } region_e;

    // plic priority or threshold level
    typedef logic [2:0] prio_t;

    // plic source id, 0 means no source
    typedef logic [2:0] src_id_t;

endpackage

/* src/addr_decoder.sv */
`timescale 1ns/100ps
`include "soc_consts.svh"

module addr_decoder import soc_pkg::*; (
    input  bus_word_t                bus_address,
    output region_e                  region,
    output logic [`RAM_INDEX_W-1:0]  ram_index,
    output src_id_t                  plic_src
);

    bus_word_t ram_off;
    bus_word_t plic_off;

    // offsets inside the ram and the priority block
    assign ram_off  = bus_address - `RAM_BASE;
    assign plic_off = bus_address - `PLIC_BASE;

    // word index, byte offset dropped
    assign ram_index = ram_off[`RAM_INDEX_W+1:2];
    // priority word offset / 4
    assign plic_src  = plic_off[4:2];

    always_comb begin
        region = rgn_none;
        if (bus_address >= `RAM_BASE &&
            bus_address < `RAM_BASE + 64'(4 * `RAM_WORDS))
            region = rgn_ram;
        else if (bus_address == `KEY_ADDR)
            region = rgn_key;
        // one priority word per source, id 0 included
        else if (bus_address >= `PLIC_BASE &&
                 bus_address < `PLIC_BASE + 64'(4 * `PLIC_SOURCES))
            region = rgn_plic_prio;
        else if (bus_address == `PLIC_PENDING)
            region = rgn_plic_pend;
        else if (bus_address == `PLIC_ENABLE)
            region = rgn_plic_en0;
        else if (bus_address == `PLIC_ENABLE + `PLIC_CTX_EN_STRIDE)
            region = rgn_plic_en1;
        else if (bus_address == `PLIC_THRESHOLD)
            region = rgn_plic_thr0;
        else if (bus_address == `PLIC_THRESHOLD + `PLIC_CTX_STRIDE)
            region = rgn_plic_thr1;
        else if (bus_address == `PLIC_CLAIM)
            region = rgn_plic_claim0;
        else if (bus_address == `PLIC_CLAIM + `PLIC_CTX_STRIDE)
            region = rgn_plic_claim1;
    end

endmodule

/* memory/word_ram.sv */
`timescale 1ns/100ps
`include "soc_consts.svh"

module word_ram import soc_pkg::*; #(
    parameter int DEPTH = `RAM_WORDS
) (
    input  logic                     CLOCK_50,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  logic [3:0]               be,
    input  ram_word_t                wdata,
    output ram_word_t                rdata
);

    ram_word_t mem [DEPTH];

    always_ff @(posedge CLOCK_50) begin
        // byte lanes written on their own enable
        for (int i = 0; i < 4; i++) begin
            if (be[i])
                mem[addr][8*i +: 8] <= wdata[8*i +: 8];
        end
        // registered read, old data on a same-cycle write
        rdata <= mem[addr];
    end

endmodule

/* memory/ram_port.sv */
`timescale 1ns/100ps
`include "soc_consts.svh"

module ram_port import soc_pkg::*; (
    input  logic                     CLOCK_50,
    input  logic                     KEY0,
    input  logic                     ram_start,
    input  logic                     ram_write,
    input  ls_type_e                 ls_type,
    input  logic [`RAM_INDEX_W-1:0]  ram_index,
    input  logic [1:0]               byte_offset,
    input  bus_word_t                write_data,
    input  ram_word_t                ram_rdata,
    output logic                     ram_finish,
    output bus_word_t                load_data,
    output logic [`RAM_INDEX_W-1:0]  ram_addr,
    output logic [3:0]               ram_be,
    output ram_word_t                ram_wdata
);

    logic      is_double;
    logic      beat;
    logic      addr_step;
    ram_word_t lo_word;

    assign is_double  = (ls_type == ls_ld);
    // single beats end at once, ld/sd on the second beat
    assign ram_finish = ram_start && (!is_double || beat);

    // ld looks ahead one word so the high half is read by beat 1
    // sd steps only on beat 1
    assign addr_step = beat || (ram_start && is_double && !ram_write);
    assign ram_addr  = ram_index + {{(`RAM_INDEX_W-1){1'b0}}, addr_step};

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            beat <= 1'b0;
        end else if (ram_start && is_double) begin
            beat <= !beat;
        end
    end

    // low half of ld
    always_ff @(posedge CLOCK_50) begin
        if (ram_start && !ram_write && is_double && !beat)
            lo_word <= ram_rdata;
    end

    // lane steering for stores
    always_comb begin
        ram_be    = 4'b0000;
        ram_wdata = write_data[31:0];
        if (ram_start && ram_write) begin
            case (ls_type)
                // sb, byte copied to every lane
                ls_lb: begin
                    ram_be    = 4'b0001 << byte_offset;
                    ram_wdata = {4{write_data[7:0]}};
                end
                // sh, low or high half
                ls_lh: begin
                    ram_be    = byte_offset[1] ? 4'b1100 : 4'b0011;
                    ram_wdata = {2{write_data[15:0]}};
                end
                // sw
                ls_lw: ram_be = 4'b1111;
                // sd, low word then high word
                ls_ld: begin
                    ram_be    = 4'b1111;
                    ram_wdata = beat ? write_data[63:32] : write_data[31:0];
                end
                default: ram_be = 4'b0000;
            endcase
        end
    end

    // loads shift right by 8*offset with zero fill
    assign load_data = is_double ? {ram_rdata, lo_word}
                                 : {32'd0, ram_rdata >> {byte_offset, 3'b000}};

    // halfword stores stay inside one word
    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (ram_start && ram_write && ls_type == ls_lh) |-> !byte_offset[0]);

endmodule

/* plic/plic_regs.sv */
`timescale 1ns/100ps
`include "soc_consts.svh"

module plic_regs import soc_pkg::*; (
    input  logic                          CLOCK_50,
    input  logic                          KEY0,
    input  logic                          reg_write,
    input  region_e                       region,
    input  src_id_t                       plic_src,
    input  bus_word_t                     write_data,
    input  logic [`PLIC_SOURCES-1:0]      irq_sources,
    output prio_t [`PLIC_SOURCES-1:0]     prio,
    output logic [`PLIC_SOURCES-1:0]      pending,
    output logic [`PLIC_SOURCES-1:0]      enable0,
    output logic [`PLIC_SOURCES-1:0]      enable1,
    output prio_t                         threshold0,
    output prio_t                         threshold1,
    output bus_word_t                     reg_rdata
);

    localparam int PAD = 64 - `PLIC_SOURCES;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            prio       <= '0;
            pending    <= '0;
            enable0    <= '0;
            enable1    <= '0;
            threshold0 <= '0;
            threshold1 <= '0;
        end else begin
            // level sources, sticky until reset
            pending <= pending | irq_sources;
            if (reg_write) begin
                case (region)
                    rgn_plic_prio: prio[plic_src] <= prio_t'(write_data[2:0]);
                    rgn_plic_en0:  enable0 <= write_data[`PLIC_SOURCES-1:0];
                    rgn_plic_en1:  enable1 <= write_data[`PLIC_SOURCES-1:0];
                    rgn_plic_thr0: threshold0 <= prio_t'(write_data[2:0]);
                    rgn_plic_thr1: threshold1 <= prio_t'(write_data[2:0]);
                    // pending and claim are not writable
                    default: ;
                endcase
            end
        end
    end

    // read side, claim comes from the arbiters
    always_comb begin
        case (region)
            rgn_plic_prio: reg_rdata = {61'd0, prio[plic_src]};
            rgn_plic_pend: reg_rdata = {{PAD{1'b0}}, pending};
            rgn_plic_en0:  reg_rdata = {{PAD{1'b0}}, enable0};
            rgn_plic_en1:  reg_rdata = {{PAD{1'b0}}, enable1};
            rgn_plic_thr0: reg_rdata = {61'd0, threshold0};
            rgn_plic_thr1: reg_rdata = {61'd0, threshold1};
            default:       reg_rdata = '0;
        endcase
    end

endmodule

/* plic/plic_arbiter.sv */
`timescale 1ns/100ps
`include "soc_consts.svh"

module plic_arbiter import soc_pkg::*; #(
    parameter int SOURCES = `PLIC_SOURCES
) (
    input  prio_t [SOURCES-1:0] prio,
    input  logic  [SOURCES-1:0] pending,
    input  logic  [SOURCES-1:0] enable,
    input  prio_t               threshold,
    output src_id_t             claim_id
);

    prio_t max_prio;

    // strict compare, the lowest id wins a tie
    always_comb begin
        max_prio = threshold;
        claim_id = '0;
        // id 0 never claims
        for (int i = 1; i < SOURCES; i++) begin
            if (pending[i] && enable[i] && prio[i] > max_prio) begin
                max_prio = prio[i];
                claim_id = src_id_t'(i);
            end
        end
        assert (claim_id < SOURCES);
    end

endmodule

/* src/soc_bus_top.sv */
`timescale 1ns/100ps
`include "soc_consts.svh"

module soc_bus_top import soc_pkg::*; (
    input  logic                     CLOCK_50,
    input  logic                     KEY0,
    input  bus_word_t                bus_address,
    input  bus_word_t                bus_write_data,
    input  logic                     bus_read_enable,
    input  logic                     bus_write_enable,
    input  ls_type_e                 bus_ls_type,
    input  logic [7:0]               key_ascii,
    input  logic [`PLIC_SOURCES-1:0] irq_sources,
    output bus_word_t                bus_read_data,
    output logic                     bus_read_done,
    output logic                     bus_write_done,
    output logic                     meip,
    output logic                     msip
);

    region_e                         region;
    logic [`RAM_INDEX_W-1:0]         ram_index;
    src_id_t                         plic_src;
    logic                            rd_exec;
    logic                            wr_exec;
    logic                            ram_start;
    logic                            ram_finish;
    bus_word_t                       load_data;
    logic [`RAM_INDEX_W-1:0]         ram_addr;
    logic [3:0]                      ram_be;
    ram_word_t                       ram_wdata;
    ram_word_t                       ram_rdata;
    prio_t [`PLIC_SOURCES-1:0]       prio;
    logic [`PLIC_SOURCES-1:0]        pending;
    logic [`PLIC_SOURCES-1:0]        enable0;
    logic [`PLIC_SOURCES-1:0]        enable1;
    prio_t                           threshold0;
    prio_t                           threshold1;
    bus_word_t                       plic_rdata;
    src_id_t                         claim0;
    src_id_t                         claim1;
    logic [7:0]                      key_reg;
    bus_word_t                       mux_rdata;

    addr_decoder i_decoder (
        .bus_address (bus_address),
        .region      (region),
        .ram_index   (ram_index),
        .plic_src    (plic_src)
    );

    // access runs once the strobe has dropped and done is still low
    assign rd_exec   = !bus_read_done && !bus_read_enable;
    assign wr_exec   = !bus_write_done && !bus_write_enable;
    assign ram_start = (rd_exec || wr_exec) && (region == rgn_ram);

    ram_port i_ram_port (
        .CLOCK_50    (CLOCK_50),
        .KEY0        (KEY0),
        .ram_start   (ram_start),
        .ram_write   (wr_exec),
        .ls_type     (bus_ls_type),
        .ram_index   (ram_index),
        .byte_offset (bus_address[1:0]),
        .write_data  (bus_write_data),
        .ram_rdata   (ram_rdata),
        .ram_finish  (ram_finish),
        .load_data   (load_data),
        .ram_addr    (ram_addr),
        .ram_be      (ram_be),
        .ram_wdata   (ram_wdata)
    );

    word_ram #(.DEPTH(`RAM_WORDS)) i_word_ram (
        .CLOCK_50 (CLOCK_50),
        .addr     (ram_addr),
        .be       (ram_be),
        .wdata    (ram_wdata),
        .rdata    (ram_rdata)
    );

    plic_regs i_plic_regs (
        .CLOCK_50    (CLOCK_50),
        .KEY0        (KEY0),
        .reg_write   (wr_exec),
        .region      (region),
        .plic_src    (plic_src),
        .write_data  (bus_write_data),
        .irq_sources (irq_sources),
        .prio        (prio),
        .pending     (pending),
        .enable0     (enable0),
        .enable1     (enable1),
        .threshold0  (threshold0),
        .threshold1  (threshold1),
        .reg_rdata   (plic_rdata)
    );

    // context 0, machine external
    plic_arbiter #(.SOURCES(`PLIC_SOURCES)) i_arb_ctx0 (
        .prio      (prio),
        .pending   (pending),
        .enable    (enable0),
        .threshold (threshold0),
        .claim_id  (claim0)
    );

    // context 1, software
    plic_arbiter #(.SOURCES(`PLIC_SOURCES)) i_arb_ctx1 (
        .prio      (prio),
        .pending   (pending),
        .enable    (enable1),
        .threshold (threshold1),
        .claim_id  (claim1)
    );

    assign meip = (claim0 != '0);
    assign msip = (claim1 != '0);

    // key code sampled every cycle
    always_ff @(posedge CLOCK_50) begin
        key_reg <= key_ascii;
    end

    // single-beat read sources, unmapped reads give zero
    always_comb begin
        case (region)
            rgn_key:         mux_rdata = {56'd0, key_reg};
            rgn_plic_claim0: mux_rdata = {61'd0, claim0};
            rgn_plic_claim1: mux_rdata = {61'd0, claim1};
            rgn_ram,
            rgn_none:        mux_rdata = '0;
            default:         mux_rdata = plic_rdata;
        endcase
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            bus_read_done  <= 1'b1;
            bus_write_done <= 1'b1;
            bus_read_data  <= '0;
        end else begin
            // strobe edge, done falls
            if (bus_read_enable)
                bus_read_done <= 1'b0;
            if (bus_write_enable)
                bus_write_done <= 1'b0;
            // ram waits for its last beat, others end here
            if (rd_exec) begin
                if (region != rgn_ram) begin
                    bus_read_data <= mux_rdata;
                    bus_read_done <= 1'b1;
                end else if (ram_finish) begin
                    bus_read_data <= load_data;
                    bus_read_done <= 1'b1;
                end
            end
            if (wr_exec && (region != rgn_ram || ram_finish))
                bus_write_done <= 1'b1;
        end
    end

    // one direction per strobe
    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        !(bus_read_enable && bus_write_enable));

    // a new strobe only while the bus is idle
    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (bus_read_enable || bus_write_enable) |-> (bus_read_done && bus_write_done));

endmodule

/* testbench/tb_soc_bus.sv */
`timescale 1ns/100ps
`include "soc_consts.svh"

module tb_soc_bus import soc_pkg::*; ();

    // about 230 accesses, sized up for margin
    localparam int ACCESSES          = 300;
    // settle, strobe, drop, up to two execute edges, one spare
    localparam int CYCLES_PER_ACCESS = 6;
    localparam int TIMEOUT_CYCLES    = ACCESSES * CYCLES_PER_ACCESS + 100;
    localparam int WORD_WRITES       = 40;

    logic                     CLOCK_50 = 1'b0;
    logic                     KEY0;
    bus_word_t                bus_address;
    bus_word_t                bus_write_data;
    logic                     bus_read_enable;
    logic                     bus_write_enable;
    ls_type_e                 bus_ls_type;
    logic [7:0]               key_ascii;
    logic [`PLIC_SOURCES-1:0] irq_sources;
    bus_word_t                bus_read_data;
    logic                     bus_read_done;
    logic                     bus_write_done;
    logic                     meip;
    logic                     msip;

    // reference model state
    logic [31:0]              ref_mem [`RAM_WORDS];
    prio_t                    prio_ref [`PLIC_SOURCES];
    logic [`PLIC_SOURCES-1:0] pend_ref = '0;
    logic [`PLIC_SOURCES-1:0] en0_ref;
    logic [`PLIC_SOURCES-1:0] en1_ref;
    prio_t                    thr0_ref;
    prio_t                    thr1_ref;

    // pending compares, filled on falling edges
    string                    name_q [$];
    bus_word_t                got_q [$];
    bus_word_t                exp_q [$];
    time                      stamp_q [$];
    string                    cmp_name;
    bus_word_t                cmp_got;
    bus_word_t                cmp_exp;
    time                      cmp_stamp;

    integer                   seed = 32'hc137;
    int                       errors = 0;
    int                       checks = 0;
    int                       cycles = 0;

    soc_bus_top i_dut (.*);

    always #10 CLOCK_50 = ~CLOCK_50;

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    function automatic bus_word_t ram_address(input logic [9:0] idx, input logic [1:0] off);
        return `RAM_BASE + {52'd0, idx, off};
    endfunction

    // load rule: ld joins two words, others shift one word down with zero fill
    function automatic bus_word_t expected_load(input ls_type_e ls, input logic [9:0] idx,
                                                input logic [1:0] off);
        if (ls == ls_ld)
            return {ref_mem[idx + 10'd1], ref_mem[idx]};
        return {32'd0, ref_mem[idx] >> (8 * off)};
    endfunction

    // claim rule: first id strictly above the running max, max starts at threshold
    function automatic src_id_t expected_claim(input logic [`PLIC_SOURCES-1:0] en,
                                               input prio_t thr);
        prio_t   best;
        src_id_t id;
        best = thr;
        id   = '0;
        for (int i = 1; i < `PLIC_SOURCES; i++) begin
            if (pend_ref[i] && en[i] && prio_ref[i] > best) begin
                best = prio_ref[i];
                id   = src_id_t'(i);
            end
        end
        return id;
    endfunction

    task automatic expect_value(input string name, input bus_word_t got, input bus_word_t exp);
        name_q.push_back(name);
        got_q.push_back(got);
        exp_q.push_back(exp);
        stamp_q.push_back($time);
    endtask

    task automatic bus_write(input bus_word_t addr, input bus_word_t data, input ls_type_e ls);
        @(negedge CLOCK_50);
        bus_address      = addr;
        bus_write_data   = data;
        bus_ls_type      = ls;
        bus_write_enable = 1'b1;
        @(negedge CLOCK_50);
        bus_write_enable = 1'b0;
        while (!bus_write_done)
            @(negedge CLOCK_50);
    endtask

    task automatic bus_read(input bus_word_t addr, input ls_type_e ls, output bus_word_t data);
        @(negedge CLOCK_50);
        bus_address     = addr;
        bus_ls_type     = ls;
        bus_read_enable = 1'b1;
        @(negedge CLOCK_50);
        bus_read_enable = 1'b0;
        while (!bus_read_done)
            @(negedge CLOCK_50);
        data = bus_read_data;
    endtask

    // store on the bus, then apply the same store to the model
    task automatic store_and_model(input logic [9:0] idx, input logic [1:0] off,
                                   input ls_type_e ls, input bus_word_t data);
        bus_write(ram_address(idx, off), data, ls);
        case (ls)
            // sb
            ls_lb: ref_mem[idx][8 * off +: 8] = data[7:0];
            // sh, lane picked by offset bit 1
            ls_lh: ref_mem[idx][16 * off[1] +: 16] = data[15:0];
            ls_lw: ref_mem[idx] = data[31:0];
            // sd, low word first
            ls_ld: begin
                ref_mem[idx]         = data[31:0];
                ref_mem[idx + 10'd1] = data[63:32];
            end
            default: ;
        endcase
    endtask

    task automatic load_and_check(input logic [9:0] idx, input logic [1:0] off,
                                  input ls_type_e ls, input string name);
        bus_word_t got;
        bus_read(ram_address(idx, off), ls, got);
        expect_value(name, got, expected_load(ls, idx, off));
    endtask

    // drain the compare queue on the rising edge
    always @(posedge CLOCK_50) begin
        while (got_q.size() != 0) begin
            cmp_name  = name_q.pop_front();
            cmp_got   = got_q.pop_front();
            cmp_exp   = exp_q.pop_front();
            cmp_stamp = stamp_q.pop_front();
            checks++;
            assert (cmp_got === cmp_exp) else begin
                errors++;
                $display("error at %0t: %s is %h, expected %h",
                         cmp_stamp, cmp_name, cmp_got, cmp_exp);
            end
        end
    end

    // hung handshake guard
    always @(posedge CLOCK_50) begin
        cycles = cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, a bus access never completed", cycles);
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin
        logic [9:0] used [WORD_WRITES];
        logic [9:0] idx;
        bus_word_t  data;
        bus_word_t  got;
        bus_address      = '0;
        bus_write_data   = '0;
        bus_read_enable  = 1'b0;
        bus_write_enable = 1'b0;
        bus_ls_type      = ls_lw;
        key_ascii        = 8'h00;
        irq_sources      = '0;
        KEY0             = 1'b0;
        repeat (4) @(negedge CLOCK_50);
        KEY0 = 1'b1;

        // reset values
        @(negedge CLOCK_50);
        expect_value("bus_read_done", {63'd0, bus_read_done}, 64'd1);
        expect_value("bus_write_done", {63'd0, bus_write_done}, 64'd1);
        expect_value("meip", {63'd0, meip}, 64'd0);
        expect_value("msip", {63'd0, msip}, 64'd0);
        expect_value("bus_read_data", bus_read_data, 64'd0);
        bus_read(`PLIC_PENDING, ls_lw, got);
        expect_value("pending", got, 64'd0);

        // word round trip, low half of the ram
        for (int i = 0; i < WORD_WRITES; i++) begin
            used[i] = 10'(rand32() % 32'd512);
            store_and_model(used[i], 2'd0, ls_lw, {rand32(), rand32()});
        end
        for (int i = 0; i < WORD_WRITES; i++)
            load_and_check(used[i], 2'd0, ls_lw, "lw");

        // byte and halfword lanes over a full word
        for (int i = 0; i < 8; i++) begin
            idx = 10'(32'd512 + rand32() % 32'd256);
            store_and_model(idx, 2'd0, ls_lw, {32'd0, rand32()});
            store_and_model(idx, 2'(rand32()), ls_lb, {32'd0, rand32()});
            store_and_model(idx, {1'(rand32()), 1'b0}, ls_lh, {32'd0, rand32()});
            load_and_check(idx, 2'd0, ls_lw, "lw merged");
            for (int n = 0; n < 4; n++)
                load_and_check(idx, 2'(n), ls_lb, "lb");
        end

        // double words in the top quarter
        for (int i = 0; i < 8; i++) begin
            idx = 10'(32'd768 + 32'd2 * (rand32() % 32'd120));
            store_and_model(idx, 2'd0, ls_ld, {rand32(), rand32()});
            load_and_check(idx, 2'd0, ls_ld, "ld");
            load_and_check(idx + 10'd1, 2'd0, ls_lw, "lw upper half");
        end

        // key register, then unmapped holes
        for (int i = 0; i < 3; i++) begin
            @(negedge CLOCK_50);
            key_ascii = 8'(rand32());
            bus_read(`KEY_ADDR, ls_lbu, got);
            expect_value("key", got, {56'd0, key_ascii});
        end
        bus_read(64'h0000_0000_0000_0800, ls_lw, got);
        expect_value("unmapped read", got, 64'd0);
        bus_read(64'h0000_0000_4000_0000, ls_ld, got);
        expect_value("unmapped ld", got, 64'd0);
        bus_write(64'h0000_0000_0000_0804, {rand32(), rand32()}, ls_lw);

        // plic priorities, id 0 included
        for (int i = 0; i < `PLIC_SOURCES; i++) begin
            data        = {rand32(), rand32()};
            prio_ref[i] = data[2:0];
            bus_write(`PLIC_BASE + 64'(4 * i), data, ls_lw);
        end
        for (int i = 0; i < `PLIC_SOURCES; i++) begin
            bus_read(`PLIC_BASE + 64'(4 * i), ls_lw, got);
            expect_value("priority", got, {61'd0, prio_ref[i]});
        end
        en0_ref = 6'(rand32());
        en1_ref = 6'(rand32());
        bus_write(`PLIC_ENABLE, {58'd0, en0_ref}, ls_lw);
        bus_write(`PLIC_ENABLE + `PLIC_CTX_EN_STRIDE, {58'd0, en1_ref}, ls_lw);
        bus_read(`PLIC_ENABLE, ls_lw, got);
        expect_value("enable0", got, {58'd0, en0_ref});
        bus_read(`PLIC_ENABLE + `PLIC_CTX_EN_STRIDE, ls_lw, got);
        expect_value("enable1", got, {58'd0, en1_ref});

        // raise sources, retune thresholds, claim each round
        for (int i = 0; i < 4; i++) begin
            @(negedge CLOCK_50);
            irq_sources = 6'(rand32());
            pend_ref    = pend_ref | irq_sources;
            @(negedge CLOCK_50);
            // pending stays set after the level drops
            irq_sources = '0;
            thr0_ref    = 3'(rand32() % 32'd4);
            thr1_ref    = 3'(rand32() % 32'd4);
            bus_write(`PLIC_THRESHOLD, {61'd0, thr0_ref}, ls_lw);
            bus_write(`PLIC_THRESHOLD + `PLIC_CTX_STRIDE, {61'd0, thr1_ref}, ls_lw);
            bus_read(`PLIC_THRESHOLD, ls_lw, got);
            expect_value("threshold0", got, {61'd0, thr0_ref});
            bus_read(`PLIC_THRESHOLD + `PLIC_CTX_STRIDE, ls_lw, got);
            expect_value("threshold1", got, {61'd0, thr1_ref});
            bus_read(`PLIC_PENDING, ls_lw, got);
            expect_value("pending", got, {58'd0, pend_ref});
            bus_read(`PLIC_CLAIM, ls_lw, got);
            expect_value("claim0", got, {61'd0, expected_claim(en0_ref, thr0_ref)});
            bus_read(`PLIC_CLAIM + `PLIC_CTX_STRIDE, ls_lw, got);
            expect_value("claim1", got, {61'd0, expected_claim(en1_ref, thr1_ref)});
            expect_value("meip", {63'd0, meip},
                         {63'd0, expected_claim(en0_ref, thr0_ref) != 3'd0});
            expect_value("msip", {63'd0, msip},
                         {63'd0, expected_claim(en1_ref, thr1_ref) != 3'd0});
        end

        // let the last compares drain
        @(posedge CLOCK_50);
        @(negedge CLOCK_50);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

/* flist.f */
+incdir+common
common/soc_pkg.sv
src/addr_decoder.sv
memory/word_ram.sv
memory/ram_port.sv
plic/plic_regs.sv
plic/plic_arbiter.sv
src/soc_bus_top.sv
testbench/tb_soc_bus.sv

/* run.sh */
#!/bin/sh
# build and run the bus testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module tb_soc_bus

out=$(./obj_dir/Vtb_soc_bus)
echo "$out"

# exit status follows the pass line
echo "$out" | grep -qx "TB PASSED"
